/* Makefile */
# Verilator build and run of the memory tile testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_tile
RTL_TOP    ?= mem_tile
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
EXTRA_ARGS ?=

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter design/%,$(SOURCES))
HEADERS     := design/mem_tile_defines.svh
SIM_BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) $(EXTRA_ARGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) --lint-only +incdir+design $(RTL_SOURCES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* design/atop_resolver.sv */
/*
 * Atomic and LR/SC sequencer in front of the SRAM row.
 * One operation at a time; a single reservation is tracked.
 * SC returns 0 on success and 1 on failure.
 */
`timescale 1ns/1ps
`include "mem_tile_defines.svh"

module atop_resolver (
  input logic     clk_i,
  input logic     rst_n_i,
  mem_port_if.sbr ni,
  mem_port_if.mgr mem
);
  import mem_tile_pkg::*;

  localparam int unsigned WORD_LSB = $clog2(`MT_DATA_W/8);
  localparam int unsigned WADDR_W  = `MT_ADDR_W - WORD_LSB;

  typedef enum logic [1:0] {
    IDLE,
    RD_WAIT,
    AMO_WRITE
  } state_e;

  state_e                state_q;
  state_e                state_d;
  mt_opcode_e            op_q;
  logic [`MT_ADDR_W-1:0] addr_q;
  logic [`MT_DATA_W-1:0] wdata_q;
  logic [`MT_DATA_W-1:0] hold_q;
  logic [`MT_DATA_W-1:0] amo_wdata;
  logic                  is_amo_q;
  logic                  is_store_q;
  logic                  res_valid_q;
  logic [WADDR_W-1:0]    res_addr_q;
  logic [`MT_ID_W-1:0]   res_src_q;
  logic                  res_hit;
  logic                  sc_ok;

  assign res_hit    = res_valid_q && (res_addr_q == ni.addr[`MT_ADDR_W-1:WORD_LSB]);
  assign sc_ok      = res_hit && (res_src_q == ni.src);
  assign is_amo_q   = (op_q == OP_AMO_ADD) || (op_q == OP_AMO_SWAP);
  assign is_store_q = (op_q == OP_WRITE) || (op_q == OP_SC);
  // Old word sits in hold_q during the write phase
  assign amo_wdata  = (op_q == OP_AMO_ADD) ? hold_q + wdata_q : wdata_q;

  always_comb begin
    state_d   = state_q;
    mem.req   = 1'b0;
    mem.we    = ni.we;
    mem.addr  = ni.addr;
    mem.wdata = ni.wdata;
    mem.be    = ni.be;
    mem.op    = ni.we ? OP_WRITE : OP_READ;
    mem.src   = ni.src;
    ni.rvalid = 1'b0;
    ni.rdata  = hold_q;
    unique case (state_q)
      IDLE: begin
        if (ni.req) begin
          // A failing SC leaves memory untouched
          mem.req = (ni.op != OP_SC) || sc_ok;
          state_d = RD_WAIT;
        end
      end
      RD_WAIT: begin
        if (is_amo_q) begin
          state_d = AMO_WRITE;
        end else begin
          ni.rvalid = 1'b1;
          if (!is_store_q) begin
            ni.rdata = mem.rdata;
          end
          state_d = IDLE;
        end
      end
      AMO_WRITE: begin
        mem.req   = 1'b1;
        mem.we    = 1'b1;
        mem.addr  = addr_q;
        mem.wdata = amo_wdata;
        mem.be    = '1;
        mem.op    = OP_WRITE;
        ni.rvalid = 1'b1;
        state_d   = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // State and reservation
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      res_valid_q <= 1'b0;
      res_addr_q  <= '0;
      res_src_q   <= '0;
    end else begin
      state_q <= state_d;
      if (ni.req) begin
        if (ni.op == OP_LR) begin
          res_valid_q <= 1'b1;
          res_addr_q  <= ni.addr[`MT_ADDR_W-1:WORD_LSB];
          res_src_q   <= ni.src;
        end else if (ni.op == OP_SC) begin
          res_valid_q <= 1'b0;
        end else if (res_hit && (ni.op inside {OP_WRITE, OP_AMO_ADD, OP_AMO_SWAP})) begin
          res_valid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ni.req) begin
      op_q    <= ni.op;
      addr_q  <= ni.addr;
      wdata_q <= ni.wdata;
      // Stores answer 0, a failing SC answers 1
      hold_q  <= ((ni.op == OP_SC) && !sc_ok) ? `MT_DATA_W'(1) : '0;
    end else if ((state_q == RD_WAIT) && mem.rvalid) begin
      hold_q <= mem.rdata;
    end
  end

  a_no_req_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ni.req |-> state_q == IDLE);

endmodule

/* design/mem_port_if.sv */
/*
 * Word-level memory access between tile blocks.
 * req is a single-cycle strobe, there is no grant.
 * op and src only carry meaning between chimney and resolver.
 */
`timescale 1ns/1ps
`include "mem_tile_defines.svh"

interface mem_port_if;
  import mem_tile_pkg::*;

  logic                    req;
  logic                    we;
  logic [`MT_ADDR_W-1:0]   addr;
  logic [`MT_DATA_W-1:0]   wdata;
  logic [`MT_DATA_W/8-1:0] be;
  mt_opcode_e              op;
  logic [`MT_ID_W-1:0]     src;
  logic                    rvalid;
  logic [`MT_DATA_W-1:0]   rdata;

  modport mgr (output req, we, addr, wdata, be, op, src, input rvalid, rdata);
  modport sbr (input req, we, addr, wdata, be, op, src, output rvalid, rdata);

endinterface

/* design/mem_tile.sv */
/*
 * Memory tile with a single local network port.
 * The link runs on clk_i; keep req_valid_i low while the tile clock is off.
 */
`timescale 1ns/1ps
`include "mem_tile_defines.svh"

module mem_tile (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      tile_rst_n_i,
  input  logic                      tile_clk_en_i,
  input  logic                      clk_rst_bypass_i,
  input  logic                      test_enable_i,
  input  logic [`MT_ID_W-1:0]       id_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  mem_tile_pkg::mt_req_pkt_t req_pkt_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output mem_tile_pkg::mt_rsp_pkt_t rsp_pkt_o
);

  logic tile_clk;
  logic tile_rst_n;

  mem_port_if ni_port ();
  mem_port_if sram_port ();

  ////////////////////////////////////////
  // Clock gating and reset
  ////////////////////////////////////////

  // Test mode keeps the tile clock running
  tile_clk_rst i_clk_rst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tile_rst_n_i     (tile_rst_n_i),
    .tile_clk_en_i    (tile_clk_en_i | test_enable_i),
    .clk_rst_bypass_i (clk_rst_bypass_i),
    .tile_clk_o       (tile_clk),
    .tile_rst_n_o     (tile_rst_n)
  );

  ////////////////////////////////////////
  // Network interface and memory
  ////////////////////////////////////////

  tile_chimney i_chimney (
    .clk_i       (tile_clk),
    .rst_n_i     (tile_rst_n),
    .id_i        (id_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_pkt_i   (req_pkt_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_pkt_o   (rsp_pkt_o),
    .mem         (ni_port.mgr)
  );

  atop_resolver i_atop_resolver (
    .clk_i   (tile_clk),
    .rst_n_i (tile_rst_n),
    .ni      (ni_port.sbr),
    .mem     (sram_port.mgr)
  );

  sram_bank_row #(
    .NUM_ROWS (`MT_BANK_ROWS)
  ) i_sram_row (
    .clk_i   (tile_clk),
    .rst_n_i (tile_rst_n),
    .mem     (sram_port.sbr)
  );

endmodule

/* design/mem_tile_defines.svh */
/*
 * Widths and sizes of the memory tile.
 * MT_SRAM_WORDS and MT_BANK_ROWS must be powers of two, since the
 * address is split into byte offset, word index and macro select.
 */
`ifndef MEM_TILE_DEFINES_SVH
`define MEM_TILE_DEFINES_SVH

// Packet fields
`define MT_ADDR_W 16
`define MT_DATA_W 32
`define MT_ID_W 4
`define MT_TXN_W 4

// Storage
`define MT_SRAM_WORDS 256
`define MT_BANK_ROWS 4

// Response buffer entries
`define MT_RSP_DEPTH 2

`endif

/* design/mem_tile_pkg.sv */
/*
 * Packet formats of the tile's local network port.
 * Every request and every response is a single flit.
 */
`include "mem_tile_defines.svh"

package mem_tile_pkg;

  typedef enum logic [2:0] {
    OP_READ     = 3'd0,
    OP_WRITE    = 3'd1,
    OP_AMO_ADD  = 3'd2,
    OP_AMO_SWAP = 3'd3,
    OP_LR       = 3'd4,
    OP_SC       = 3'd5
  } mt_opcode_e;

  typedef enum logic [1:0] {
    ST_OK       = 2'd0,
    ST_BAD_DEST = 2'd1,
    ST_BAD_ADDR = 2'd2
  } mt_status_e;

  typedef struct packed {
    mt_opcode_e                opcode;
    logic [`MT_ID_W-1:0]       dst_id;
    logic [`MT_ID_W-1:0]       src_id;
    logic [`MT_TXN_W-1:0]      txn_id;
    logic [`MT_ADDR_W-1:0]     addr;
    logic [`MT_DATA_W-1:0]     wdata;
    logic [`MT_DATA_W/8-1:0]   be;
  } mt_req_pkt_t;

  // dst_id is the requester
  typedef struct packed {
    logic [`MT_ID_W-1:0]  dst_id;
    logic [`MT_TXN_W-1:0] txn_id;
    mt_status_e           status;
    logic [`MT_DATA_W-1:0] rdata;
  } mt_rsp_pkt_t;

endpackage

/* design/sram_bank_row.sv */
/*
 * Row of single-port SRAM macros, one word wide each.
 * Reads return one cycle after the strobe, writes give no rvalid.
 * Address bits above the macro select are not decoded here.
 */
`timescale 1ns/1ps
`include "mem_tile_defines.svh"

module sram_bank_row #(
  parameter int unsigned NUM_ROWS = `MT_BANK_ROWS
) (
  input logic     clk_i,
  input logic     rst_n_i,
  mem_port_if.sbr mem
);

  localparam int unsigned NUM_BYTES = `MT_DATA_W / 8;
  localparam int unsigned IDX_W     = $clog2(`MT_SRAM_WORDS);
  localparam int unsigned SEL_W     = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;
  localparam int unsigned IDX_LSB   = $clog2(NUM_BYTES);
  localparam int unsigned SEL_LSB   = IDX_LSB + IDX_W;

  logic [IDX_W-1:0]      word_idx;
  logic [SEL_W-1:0]      macro_sel;
  logic [SEL_W-1:0]      macro_sel_q;
  logic                  rvalid_q;
  logic [`MT_DATA_W-1:0] row_rdata [NUM_ROWS];

  assign word_idx  = mem.addr[IDX_LSB +: IDX_W];
  assign macro_sel = mem.addr[SEL_LSB +: SEL_W];

  for (genvar r = 0; r < NUM_ROWS; r++) begin : gen_macro
    logic [`MT_DATA_W-1:0] words_q [`MT_SRAM_WORDS];
    logic [`MT_DATA_W-1:0] rdata_q;
    logic                  macro_req;

    // Only the addressed macro sees the strobe
    assign macro_req = mem.req && (macro_sel == SEL_W'(r));

    always_ff @(posedge clk_i) begin
      if (macro_req) begin
        if (mem.we) begin
          for (int b = 0; b < NUM_BYTES; b++) begin
            if (mem.be[b]) begin
              words_q[word_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
            end
          end
        end else begin
          rdata_q <= words_q[word_idx];
        end
      end
    end

    assign row_rdata[r] = rdata_q;
  end

  // Select is kept for the cycle in which read data comes back
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      macro_sel_q <= '0;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= mem.req && !mem.we;
      if (mem.req && !mem.we) begin
        macro_sel_q <= macro_sel;
      end
    end
  end

  assign mem.rvalid = rvalid_q;
  assign mem.rdata  = row_rdata[macro_sel_q];

  // Full upper address must name an existing macro
  a_sel_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem.req |-> (mem.addr >> SEL_LSB) < NUM_ROWS);

endmodule

/* design/tile_chimney.sv */
/*
 * Network interface of the memory tile.
 * At most one memory access is in flight; rejected packets
 * bypass the resolver but keep their place in the response order.
 */
`timescale 1ns/1ps
`include "mem_tile_defines.svh"

module tile_chimney (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`MT_ID_W-1:0]       id_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  mem_tile_pkg::mt_req_pkt_t req_pkt_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output mem_tile_pkg::mt_rsp_pkt_t rsp_pkt_o,
  mem_port_if.mgr                   mem
);
  import mem_tile_pkg::*;

  localparam int unsigned DEPTH   = `MT_RSP_DEPTH;
  localparam int unsigned PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned TILE_AW = $clog2(`MT_DATA_W/8) + $clog2(`MT_SRAM_WORDS) +
                                    $clog2(`MT_BANK_ROWS);

  mt_status_e       chk_status;
  logic             rejected;
  logic             full;
  logic             accept;
  logic             issue;
  logic             pop;
  logic             busy_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] pend_ptr_q;
  logic [PTR_W:0]   count_q;
  logic [DEPTH-1:0] done_q;
  mt_rsp_pkt_t      entry_q [DEPTH];

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Destination is checked before the address range
  always_comb begin
    if (req_pkt_i.dst_id != id_i) begin
      chk_status = ST_BAD_DEST;
    end else if (req_pkt_i.addr[`MT_ADDR_W-1:TILE_AW] != '0) begin
      chk_status = ST_BAD_ADDR;
    end else begin
      chk_status = ST_OK;
    end
  end

  assign rejected    = (chk_status != ST_OK);
  assign full        = (count_q == (PTR_W+1)'(DEPTH));
  // Accesses also wait for the resolver, rejects need only a slot
  assign req_ready_o = !full && (rejected || !busy_q);
  assign accept      = req_valid_i && req_ready_o;
  assign issue       = accept && !rejected;

  assign mem.req   = issue;
  assign mem.we    = (req_pkt_i.opcode == OP_WRITE) || (req_pkt_i.opcode == OP_SC);
  assign mem.addr  = req_pkt_i.addr;
  assign mem.wdata = req_pkt_i.wdata;
  assign mem.be    = req_pkt_i.be;
  assign mem.op    = req_pkt_i.opcode;
  assign mem.src   = req_pkt_i.src_id;

  ////////////////////////////////////////
  // Response buffer
  ////////////////////////////////////////

  assign rsp_valid_o = (count_q != '0) && done_q[rd_ptr_q];
  assign rsp_pkt_o   = entry_q[rd_ptr_q];
  assign pop         = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      pend_ptr_q <= '0;
      count_q    <= '0;
      done_q     <= '0;
      busy_q     <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr_q         <= ptr_next(wr_ptr_q);
        done_q[wr_ptr_q] <= rejected;
      end
      if (issue) begin
        busy_q     <= 1'b1;
        pend_ptr_q <= wr_ptr_q;
      end else if (mem.rvalid) begin
        busy_q <= 1'b0;
      end
      if (mem.rvalid) begin
        done_q[pend_ptr_q] <= 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (accept && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !accept) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_q[wr_ptr_q] <= '{dst_id: req_pkt_i.src_id, txn_id: req_pkt_i.txn_id,
                             status: chk_status, rdata: '0};
    end
    // Read data joins the header reserved at issue time
    if (mem.rvalid) begin
      entry_q[pend_ptr_q].rdata <= mem.rdata;
    end
  end

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_pkt_o));

endmodule

/* design/tile_clk_rst.sv */
/*
 * Tile clock gate and reset select.
 * Bypass keeps the clock running and uses the system reset.
 * The enable may change at any time, the latch hides it while clk_i is high.
 */
`timescale 1ns/1ps

module tile_clk_rst (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic tile_rst_n_i,
  input  logic tile_clk_en_i,
  input  logic clk_rst_bypass_i,
  output logic tile_clk_o,
  output logic tile_rst_n_o
);

  logic clk_en_latch;

  // Transparent while the clock is low
  always_latch begin
    if (!clk_i) begin
      clk_en_latch <= tile_clk_en_i | clk_rst_bypass_i;
    end
  end

  assign tile_clk_o = clk_i & clk_en_latch;

  assign tile_rst_n_o = clk_rst_bypass_i ? rst_n_i : tile_rst_n_i;

endmodule

/* list.f */
+incdir+design
design/mem_tile_pkg.sv
design/mem_port_if.sv
design/tile_clk_rst.sv
design/sram_bank_row.sv
design/atop_resolver.sv
design/tile_chimney.sv
design/mem_tile.sv
testbench/tb_mem_tile.sv

/* testbench/tb_mem_tile.sv */
/*
 * Testbench of the memory tile on its local network port.
 * SRAM content is unknown until written, so every test only touches
 * words of the address pool, which the first test fills completely.
 */
`timescale 1ns/1ps
`include "mem_tile_defines.svh"

module tb_mem_tile;
  import mem_tile_pkg::*;

  localparam logic [`MT_ID_W-1:0] TILE_ID = 4'h5;
  localparam logic [`MT_ID_W-1:0] BAD_ID  = 4'h3;
  localparam logic [`MT_ID_W-1:0] SRC_A   = 4'h2;
  localparam logic [`MT_ID_W-1:0] SRC_B   = 4'h7;

  localparam int unsigned N_POOL      = 8;
  localparam int unsigned N_RAND_WR   = 16;
  localparam int unsigned N_STALL_REQ = 24;
  localparam int unsigned STALL_LEN   = 512;
  localparam int unsigned WAIT_LIMIT  = 200;
  localparam int unsigned TOTAL_REQS  = (2 * N_POOL + N_RAND_WR) + (8 + N_POOL) + 9 + 6 +
                                        N_STALL_REQ + 3;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_REQS * 20 + 200;

  localparam int RSP_ALWAYS  = 0;
  localparam int RSP_PATTERN = 1;
  localparam int RSP_HOLD    = 2;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  tile_rst_n_i;
  logic                  tile_clk_en_i;
  logic                  clk_rst_bypass_i;
  logic                  test_enable_i;
  logic [`MT_ID_W-1:0]   id_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  mt_req_pkt_t           req_pkt_i;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  mt_rsp_pkt_t           rsp_pkt_o;

  int                    seed = 62;
  string                 test_name;
  int                    rsp_mode;
  int                    stall_idx;
  logic                  stall_pat [STALL_LEN];
  logic [`MT_TXN_W-1:0]  txn_ctr;
  int unsigned           req_count;
  int unsigned           rsp_count;
  mt_rsp_pkt_t           exp_q [$];
  logic [`MT_ADDR_W-1:0] pool [N_POOL];

  // Reference state: word memory and one reservation
  logic [`MT_DATA_W-1:0]  model_mem [1024];
  logic                   model_res_valid;
  logic [`MT_ADDR_W-3:0]  model_res_word;
  logic [`MT_ID_W-1:0]    model_res_src;

  mem_tile u_dut (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tile_rst_n_i     (tile_rst_n_i),
    .tile_clk_en_i    (tile_clk_en_i),
    .clk_rst_bypass_i (clk_rst_bypass_i),
    .test_enable_i    (test_enable_i),
    .id_i             (id_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .req_pkt_i        (req_pkt_i),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i),
    .rsp_pkt_o        (rsp_pkt_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [`MT_DATA_W-1:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic [`MT_DATA_W-1:0] merge_bytes(input logic [`MT_DATA_W-1:0] old,
      input logic [`MT_DATA_W-1:0] wdata, input logic [`MT_DATA_W/8-1:0] be);
    merge_bytes = old;
    for (int b = 0; b < `MT_DATA_W / 8; b++) begin
      if (be[b]) begin
        merge_bytes[8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endfunction

  function automatic mt_rsp_pkt_t ref_response(input mt_req_pkt_t pkt);
    mt_rsp_pkt_t           rsp;
    logic [9:0]            w;
    logic [`MT_DATA_W-1:0] old;
    logic                  res_match;
    rsp.dst_id = pkt.src_id;
    rsp.txn_id = pkt.txn_id;
    rsp.status = ST_OK;
    rsp.rdata  = '0;
    w          = pkt.addr[11:2];
    res_match  = model_res_valid && (model_res_word == pkt.addr[`MT_ADDR_W-1:2]);
    if (pkt.dst_id != TILE_ID) begin
      rsp.status = ST_BAD_DEST;
    end else if (pkt.addr[`MT_ADDR_W-1:12] != '0) begin
      rsp.status = ST_BAD_ADDR;
    end else begin
      old = model_mem[w];
      case (pkt.opcode)
        OP_READ: rsp.rdata = old;
        OP_WRITE: begin
          model_mem[w] = merge_bytes(old, pkt.wdata, pkt.be);
          model_res_valid = model_res_valid && !res_match;
        end
        OP_AMO_ADD, OP_AMO_SWAP: begin
          rsp.rdata = old;
          model_mem[w] = (pkt.opcode == OP_AMO_ADD) ? old + pkt.wdata : pkt.wdata;
          model_res_valid = model_res_valid && !res_match;
        end
        OP_LR: begin
          rsp.rdata       = old;
          model_res_valid = 1'b1;
          model_res_word  = pkt.addr[`MT_ADDR_W-1:2];
          model_res_src   = pkt.src_id;
        end
        OP_SC: begin
          if (res_match && (model_res_src == pkt.src_id)) begin
            model_mem[w] = merge_bytes(old, pkt.wdata, pkt.be);
          end else begin
            rsp.rdata = `MT_DATA_W'(1);
          end
          model_res_valid = 1'b0;
        end
        default: rsp.rdata = '0;
      endcase
    end
    return rsp;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_status(input string test, input mt_status_e exp, input mt_status_e act);
    if (act !== exp) begin
      $display("Error %s: status expected %s actual %s", test, exp.name(), act.name());
      stop_with_failure();
    end
  endtask

  task automatic check_rdata(input string test, input logic [`MT_DATA_W-1:0] exp,
      input logic [`MT_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("Error %s: rdata expected %h actual %h", test, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_tag(input string test, input logic [`MT_ID_W-1:0] exp_dst,
      input logic [`MT_TXN_W-1:0] exp_txn, input logic [`MT_ID_W-1:0] act_dst,
      input logic [`MT_TXN_W-1:0] act_txn);
    if ((act_dst !== exp_dst) || (act_txn !== exp_txn)) begin
      $display("Error %s: tag expected dst %h txn %h actual dst %h txn %h",
               test, exp_dst, exp_txn, act_dst, act_txn);
      stop_with_failure();
    end
  endtask

  // A response is taken at the rising edge after this sample
  always @(negedge clk_i) begin : compare_rsp
    mt_rsp_pkt_t exp_rsp;
    if (tile_rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Response txn %0d arrived with no request outstanding", rsp_pkt_o.txn_id);
        stop_with_failure();
      end else begin
        exp_rsp = exp_q.pop_front();
        check_tag(test_name, exp_rsp.dst_id, exp_rsp.txn_id, rsp_pkt_o.dst_id, rsp_pkt_o.txn_id);
        check_status(test_name, exp_rsp.status, rsp_pkt_o.status);
        check_rdata(test_name, exp_rsp.rdata, rsp_pkt_o.rdata);
        rsp_count++;
      end
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (rsp_mode == RSP_PATTERN) begin
      rsp_ready_i = stall_pat[stall_idx];
      stall_idx   = (stall_idx + 1) % STALL_LEN;
    end else begin
      rsp_ready_i = (rsp_mode == RSP_ALWAYS);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic send_op(input mt_opcode_e op, input logic [`MT_ID_W-1:0] dst,
      input logic [`MT_ID_W-1:0] src, input logic [`MT_ADDR_W-1:0] addr,
      input logic [`MT_DATA_W-1:0] wdata, input logic [`MT_DATA_W/8-1:0] be);
    mt_req_pkt_t pkt;
    int unsigned waited;
    logic        taken;
    pkt         = '{opcode: op, dst_id: dst, src_id: src, txn_id: txn_ctr,
                    addr: addr, wdata: wdata, be: be};
    waited      = 0;
    taken       = 1'b0;
    req_pkt_i   = pkt;
    req_valid_i = 1'b1;
    while (!taken && (waited < WAIT_LIMIT)) begin
      @(negedge clk_i);
      if (req_ready_o) begin
        taken = 1'b1;
        exp_q.push_back(ref_response(pkt));
        req_count++;
      end
      waited++;
      @(posedge clk_i);
      #1;
    end
    if (!taken) begin
      $display("Request txn %0d was not accepted within %0d cycles", pkt.txn_id, WAIT_LIMIT);
      stop_with_failure();
    end
    req_valid_i = 1'b0;
    txn_ctr++;
  endtask

  task automatic send_local(input mt_opcode_e op, input logic [`MT_ADDR_W-1:0] addr,
      input logic [`MT_DATA_W-1:0] wdata, input logic [`MT_DATA_W/8-1:0] be);
    send_op(op, TILE_ID, SRC_A, addr, wdata, be);
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while ((exp_q.size() != 0) && (waited < WAIT_LIMIT)) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d responses still missing in %s", exp_q.size(), test_name);
      stop_with_failure();
    end
  endtask

  // Two words per macro, the upper half of the pool in the upper half of each macro
  task automatic fill_pool();
    logic [`MT_DATA_W-1:0] rnd;
    logic [2:0]            k;
    for (int i = 0; i < N_POOL; i++) begin
      rnd     = rand_word();
      k       = i[2:0];
      pool[i] = {4'h0, k[1:0], k[2], rnd[6:0], 2'b00};
    end
  endtask

  task automatic run_write_read();
    logic [`MT_DATA_W-1:0] rnd;
    for (int i = 0; i < N_POOL; i++) begin
      send_local(OP_WRITE, pool[i], rand_word(), 4'hf);
    end
    for (int i = 0; i < N_RAND_WR; i++) begin
      rnd = rand_word();
      send_local(OP_WRITE, pool[rnd[2:0]], rand_word(), rnd[7:4]);
    end
    for (int i = 0; i < N_POOL; i++) begin
      send_local(OP_READ, pool[i], '0, '0);
    end
  endtask

  task automatic run_amo();
    for (int i = 0; i < 4; i++) begin
      send_local(OP_AMO_ADD, pool[i], rand_word(), 4'h0);
      send_local(OP_AMO_SWAP, pool[i+4], rand_word(), 4'h0);
    end
    for (int i = 0; i < N_POOL; i++) begin
      send_local(OP_READ, pool[i], '0, '0);
    end
  endtask

  task automatic run_lr_sc();
    send_op(OP_LR, TILE_ID, SRC_A, pool[2], '0, 4'hf);
    send_op(OP_SC, TILE_ID, SRC_A, pool[2], 32'hc0de_0001, 4'hf);
    send_op(OP_SC, TILE_ID, SRC_A, pool[2], 32'hc0de_0002, 4'hf);
    send_op(OP_LR, TILE_ID, SRC_A, pool[2], '0, 4'hf);
    send_op(OP_SC, TILE_ID, SRC_B, pool[2], 32'hc0de_0003, 4'hf);
    send_op(OP_LR, TILE_ID, SRC_A, pool[2], '0, 4'hf);
    send_op(OP_WRITE, TILE_ID, SRC_B, pool[2], 32'h0000_5a5a, 4'h3);
    send_op(OP_SC, TILE_ID, SRC_A, pool[2], 32'hc0de_0004, 4'hf);
    send_op(OP_READ, TILE_ID, SRC_A, pool[2], '0, '0);
  endtask

  // Rejects follow accesses back to back, so they queue behind work in flight
  task automatic run_reject();
    send_op(OP_WRITE, BAD_ID, SRC_A, pool[0], 32'hdead_beef, 4'hf);
    send_local(OP_WRITE, pool[1] | 16'h4000, 32'hdead_beef, 4'hf);
    send_local(OP_READ, pool[0], '0, '0);
    send_op(OP_READ, BAD_ID, SRC_B, pool[1], '0, '0);
    send_local(OP_READ, pool[1] | 16'h8000, '0, '0);
    send_local(OP_READ, pool[1], '0, '0);
  endtask

  task automatic run_backpressure();
    logic [`MT_DATA_W-1:0] rnd;
    logic                  level;
    int                    run_left;
    mt_opcode_e            op;
    run_left = 0;
    level    = 1'b1;
    for (int i = 0; i < STALL_LEN; i++) begin
      if (run_left == 0) begin
        rnd      = rand_word();
        level    = rnd[0];
        run_left = 1 + int'(rnd[4:2]);
      end
      stall_pat[i] = level;
      run_left--;
    end
    stall_idx = 0;
    rsp_mode  = RSP_PATTERN;
    for (int i = 0; i < N_STALL_REQ; i++) begin
      rnd = rand_word();
      case (rnd[1:0])
        2'd0: op = OP_READ;
        2'd1: op = OP_WRITE;
        2'd2: op = OP_AMO_ADD;
        default: op = OP_AMO_SWAP;
      endcase
      send_op(op, (rnd[10:8] == 3'd0) ? BAD_ID : TILE_ID, SRC_B, pool[rnd[6:4]],
              rand_word(), rnd[15:12]);
    end
    wait_drain();
    rsp_mode = RSP_ALWAYS;
  endtask

  task automatic run_clock_gate();
    rsp_mode = RSP_HOLD;
    wait_cycles(2);
    send_local(OP_AMO_ADD, pool[3], 32'h0000_0101, 4'hf);
    tile_clk_en_i = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      if (rsp_valid_o !== 1'b0) begin
        $display("A response appeared while the tile clock was off");
        stop_with_failure();
      end
    end
    @(posedge clk_i);
    #1;
    tile_clk_en_i = 1'b1;
    rsp_mode      = RSP_ALWAYS;
    wait_drain();
    send_local(OP_READ, pool[3], '0, '0);
    send_local(OP_READ, pool[7], '0, '0);
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    tile_rst_n_i     = 1'b0;
    tile_clk_en_i    = 1'b1;
    clk_rst_bypass_i = 1'b0;
    test_enable_i    = 1'b0;
    id_i             = TILE_ID;
    req_valid_i      = 1'b0;
    req_pkt_i        = '0;
    rsp_ready_i      = 1'b1;
    rsp_mode         = RSP_ALWAYS;
    stall_idx        = 0;
    txn_ctr          = '0;
    req_count        = 0;
    rsp_count        = 0;
    model_res_valid  = 1'b0;
    model_res_word   = '0;
    model_res_src    = '0;
    test_name        = "reset";
    fill_pool();
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i      = 1'b1;
    tile_rst_n_i = 1'b1;
    wait_cycles(1);

    test_name = "write_read";
    run_write_read();
    wait_drain();
    test_name = "amo";
    run_amo();
    wait_drain();
    test_name = "lr_sc";
    run_lr_sc();
    wait_drain();
    test_name = "reject";
    run_reject();
    wait_drain();
    test_name = "backpressure";
    run_backpressure();
    test_name = "clock_gate";
    run_clock_gate();
    wait_drain();

    if ((exp_q.size() == 0) && (rsp_count == req_count)) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Sent %0d requests but received %0d responses", req_count, rsp_count);
      stop_with_failure();
    end
  end

endmodule
